// ==== vlog.f ====
crc_pkg.sv
crc_host_interface.sv
crc_input_buffer.sv
crc_engine.sv
crc_ahb.sv
crc_ahb_properties.sv
crc_ahb_tb.sv

// ==== Makefile ====
# Verilator build and run of the CRC AHB-Lite slave testbench

VERILATOR ?= verilator
TOP       ?= crc_ahb_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== crc_ahb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_tb;
	import crc_pkg::*;

	localparam int BUFFER_DEPTH   = 2;
	localparam int TIMEOUT_CYCLES = 200;

	typedef enum logic [1:0] {op_write, op_read, op_stalls} op_t;

	// One row of the stimulus table
	typedef struct {
		string       name;
		op_t         op;
		logic [2:0]  addr;
		logic [1:0]  size;
		logic [31:0] data;
		bit          check;
	} step_t;

	logic        HCLK;
	logic        HRESETn;
	logic        HSELx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	step_t       steps[$];
	integer      seed;
	int          data_stalls;

	// Reference model state
	logic [31:0] ref_crc;
	logic [31:0] ref_init;
	logic [31:0] ref_poly;
	logic [7:0]  ref_idr;
	logic [7:0]  ref_cr;

	crc_ahb #(.BUFFER_DEPTH(BUFFER_DEPTH)) dut0 (
		.HCLK(HCLK), .HRESETn(HRESETn), .HSELx(HSELx), .HADDR(HADDR),
		.HTRANS(HTRANS), .HWRITE(HWRITE), .HSIZE(HSIZE), .HWDATA(HWDATA),
		.HREADY(HREADY), .HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP)
	);

	// 40 ns period
	initial
	begin
		HCLK = 1'b0;
		forever
			#20 HCLK = ~HCLK;
	end

	//////////////////////////////////////////////////
	// Reference CRC model
	//////////////////////////////////////////////////

	function automatic int width_of(input logic [7:0] cr);
		case (cr[4:3])
			2'd0:    return 32;
			2'd1:    return 16;
			2'd2:    return 8;
			default: return 7;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		return (w >= 32) ? 32'hffff_ffff : ((32'h1 << w) - 32'h1);
	endfunction

	// Mirror every span-wide chunk of the word
	function automatic logic [31:0] reflect_chunks(input logic [31:0] d, input int span);
		logic [31:0] r;
		r = d;
		for (int base = 0; base < 32; base += span)
			for (int k = 0; k < span; k++)
				r[base + k] = d[base + span - 1 - k];
		return r;
	endfunction

	// Left-aligned shift register, MSB of the data first
	function automatic logic [31:0] fold_bits(input logic [31:0] crc, input logic [31:0] bits,
			input int nbits, input logic [31:0] poly, input int w);
		logic [31:0] acc;
		logic [31:0] pl;
		logic        fb;
		acc = (crc & width_mask(w)) << (32 - w);
		pl  = poly << (32 - w);
		for (int i = nbits - 1; i >= 0; i--)
		begin
			fb  = acc[31] ^ bits[i];
			acc = acc << 1;
			if (fb)
				acc = acc ^ pl;
		end
		return acc >> (32 - w);
	endfunction

	// DR as the host sees it, output reversal over the width
	function automatic logic [31:0] dr_view();
		logic [31:0] v;
		logic [31:0] r;
		int          w;
		w = width_of(ref_cr);
		v = ref_crc & width_mask(w);
		r = '0;
		for (int k = 0; k < w; k++)
			r[k] = v[w - 1 - k];
		return ref_cr[7] ? r : v;
	endfunction

	function automatic logic [31:0] expected_read(input logic [2:0] addr);
		case (addr)
			crc_dr_addr:   return dr_view();
			crc_idr_addr:  return {24'h0, ref_idr};
			crc_cr_addr:   return {24'h0, ref_cr};
			crc_init_addr: return ref_init;
			crc_pol_addr:  return ref_poly;
			default:       return 32'h0;
		endcase
	endfunction

	task automatic apply_write(input step_t s);
		int nbits;
		int span;
		nbits = 8 << s.size;
		span  = (ref_cr[6:5] == 2'd0) ? 1 : (4 << ref_cr[6:5]);
		// Reversal never wider than the transfer
		if (span > nbits)
			span = nbits;
		case (s.addr)
			crc_dr_addr:   ref_crc = fold_bits(ref_crc, reflect_chunks(s.data, span), nbits,
			                                   ref_poly, width_of(ref_cr));
			crc_idr_addr:  ref_idr = s.data[7:0];
			crc_init_addr: ref_init = s.data;
			crc_pol_addr:  ref_poly = s.data;
			crc_cr_addr:
			begin
				ref_cr = s.data[7:0] & 8'hf8;
				if (s.data[0])
					ref_crc = ref_init & width_mask(width_of(ref_cr));
			end
			default:       ;
		endcase
	endtask

	//////////////////////////////////////////////////
	// Bus and check tasks
	//////////////////////////////////////////////////

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Ends just after the edge that completes the phase
	task automatic wait_ready(input string what, output logic [31:0] rdata, output int stalls);
		int cycles;
		cycles = 0;
		@(negedge HCLK);
		while (HREADYOUT !== 1'b1)
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("Timeout: HREADYOUT stayed low too long in %s", what);
				$display("** FAIL **");
				$fatal(1, "Bus transfer never completed");
			end
			@(negedge HCLK);
		end
		// OKAY response
		compare({what, " HRESP"}, 32'h0, {31'h0, HRESP});
		rdata  = HRDATA;
		stalls = cycles;
		@(posedge HCLK);
	endtask

	// Single NONSEQ transfer followed by IDLE
	task automatic bus_transfer(input step_t s, output logic [31:0] rdata, output int stalls);
		logic [31:0] unused;
		int          addr_stalls;
		HSELx  <= 1'b1;
		HADDR  <= {27'h0, s.addr, 2'b00};
		HTRANS <= htrans_nonseq;
		HWRITE <= (s.op == op_write);
		HSIZE  <= {1'b0, s.size};
		wait_ready({s.name, " address phase"}, unused, addr_stalls);
		HSELx  <= 1'b0;
		HTRANS <= htrans_idle;
		if (s.op == op_write)
			HWDATA <= s.data;
		wait_ready({s.name, " data phase"}, rdata, stalls);
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////

	task automatic push_step(input string name, input op_t op, input logic [2:0] addr,
			input logic [1:0] size, input logic [31:0] data, input bit check);
		step_t s;
		s.name  = name;
		s.op    = op;
		s.addr  = addr;
		s.size  = size;
		s.data  = data;
		s.check = check;
		steps.push_back(s);
	endtask

	task automatic random_data_writes(input string name, input logic [1:0] size, input int count);
		for (int i = 0; i < count; i++)
			push_step(name, op_write, crc_dr_addr, size, $random(seed), 1'b0);
	endtask

	function automatic logic [7:0] cr_bits(input int psel, input int rin, input bit rout);
		// Always with the chain reset bit set
		return {rout, 2'(rin), 2'(psel), 2'b00, 1'b1};
	endfunction

	// POL, INIT, then CR with reset and an immediate DR read
	task automatic setup_chain(input string name, input logic [31:0] poly,
			input logic [31:0] init, input logic [7:0] cr);
		push_step(name, op_write, crc_pol_addr, size_word, poly, 1'b0);
		push_step(name, op_write, crc_init_addr, size_word, init, 1'b0);
		push_step(name, op_write, crc_cr_addr, size_word, {24'h0, cr}, 1'b0);
		push_step(name, op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
	endtask

	task automatic build_table();
		// Reset values
		push_step("reset_cr", op_read, crc_cr_addr, size_word, 32'h0, 1'b1);
		push_step("reset_init", op_read, crc_init_addr, size_word, 32'h0, 1'b1);
		push_step("reset_pol", op_read, crc_pol_addr, size_word, 32'h0, 1'b1);
		push_step("reset_idr", op_read, crc_idr_addr, size_word, 32'h0, 1'b1);
		push_step("reset_dr", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		// Register readback, CR bit 0 reads as zero
		push_step("init_wr", op_write, crc_init_addr, size_word, 32'h5a5a_c3c3, 1'b0);
		push_step("init_rb", op_read, crc_init_addr, size_word, 32'h0, 1'b1);
		push_step("pol_wr", op_write, crc_pol_addr, size_word, 32'h1edc_6f41, 1'b0);
		push_step("pol_rb", op_read, crc_pol_addr, size_word, 32'h0, 1'b1);
		push_step("idr_wr", op_write, crc_idr_addr, size_word, $random(seed), 1'b0);
		push_step("idr_rb", op_read, crc_idr_addr, size_word, 32'h0, 1'b1);
		push_step("cr_wr", op_write, crc_cr_addr, size_word, 32'h0000_00ff, 1'b0);
		push_step("cr_rb", op_read, crc_cr_addr, size_word, 32'h0, 1'b1);
		// CRC-32 over words
		setup_chain("crc32_reset", 32'h04c1_1db7, 32'hffff_ffff, cr_bits(0, 0, 1'b0));
		random_data_writes("crc32_wr", size_word, 6);
		push_step("crc32_words", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		// Narrow polynomials with byte and halfword writes
		setup_chain("crc16_reset", 32'h0000_1021, 32'h0000_ffff, cr_bits(1, 0, 1'b0));
		random_data_writes("crc16_wr", size_half, 4);
		random_data_writes("crc16_wr", size_byte, 2);
		push_step("crc16_mixed", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		setup_chain("crc8_reset", 32'h0000_0007, 32'h0000_0000, cr_bits(2, 0, 1'b0));
		random_data_writes("crc8_wr", size_byte, 5);
		push_step("crc8_bytes", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		setup_chain("crc7_reset", 32'h0000_0009, 32'h0000_0000, cr_bits(3, 0, 1'b0));
		random_data_writes("crc7_wr", size_byte, 3);
		random_data_writes("crc7_wr", size_half, 2);
		push_step("crc7_mixed", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		// Input reversal modes, then output reversal
		for (int m = 1; m < 4; m++)
		begin
			setup_chain($sformatf("rev_in%0d_reset", m), 32'h04c1_1db7, 32'hffff_ffff,
			            cr_bits(0, m, 1'b0));
			random_data_writes($sformatf("rev_in%0d_wr", m), size_word, 2);
			random_data_writes($sformatf("rev_in%0d_wr", m), size_half, 1);
			random_data_writes($sformatf("rev_in%0d_wr", m), size_byte, 1);
			push_step($sformatf("rev_in%0d", m), op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		end
		setup_chain("rev_out32_reset", 32'h04c1_1db7, 32'hffff_ffff, cr_bits(0, 3, 1'b1));
		random_data_writes("rev_out32_wr", size_word, 3);
		push_step("rev_out32", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		setup_chain("rev_out16_reset", 32'h0000_8005, 32'h0000_0000, cr_bits(1, 1, 1'b1));
		random_data_writes("rev_out16_wr", size_half, 3);
		random_data_writes("rev_out16_wr", size_byte, 1);
		push_step("rev_out16", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		// Run longer than the buffer, wait states expected
		setup_chain("burst_reset", 32'h04c1_1db7, 32'hffff_ffff, cr_bits(0, 0, 1'b0));
		push_step("burst_clear", op_stalls, 3'd0, size_word, 32'h0, 1'b0);
		random_data_writes("burst_wr", size_word, 4 * BUFFER_DEPTH + 2);
		push_step("burst_waits", op_stalls, 3'd0, size_word, 32'h0, 1'b1);
		push_step("burst_crc", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		// Chain reset behind queued words, INIT write stalls until the reload
		random_data_writes("queued_wr", size_word, 3);
		push_step("queued_reset", op_write, crc_cr_addr, size_word,
		          {24'h0, cr_bits(0, 0, 1'b0)}, 1'b0);
		push_step("queued_init", op_write, crc_init_addr, size_word, 32'h1234_5678, 1'b0);
		push_step("queued_dr", op_read, crc_dr_addr, size_word, 32'h0, 1'b1);
		push_step("queued_init_rb", op_read, crc_init_addr, size_word, 32'h0, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		int          stalls;
		HRESETn     = 1'b0;
		HSELx       = 1'b0;
		HADDR       = 32'h0;
		HTRANS      = htrans_idle;
		HWRITE      = 1'b0;
		HSIZE       = 3'b000;
		HWDATA      = 32'h0;
		HREADY      = 1'b1;
		seed        = 32'h38b371ca;
		data_stalls = 0;
		ref_crc     = 32'hffff_ffff;
		ref_init    = 32'hffff_ffff;
		ref_poly    = 32'h04c1_1db7;
		ref_idr     = 8'h00;
		ref_cr      = 8'h00;
		build_table();
		repeat (3)
			@(posedge HCLK);
		HRESETn <= 1'b1;
		foreach (steps[i])
		begin
			case (steps[i].op)
				op_write:
				begin
					bus_transfer(steps[i], rdata, stalls);
					if (steps[i].addr == crc_dr_addr)
						data_stalls += stalls;
					apply_write(steps[i]);
				end
				op_read:
				begin
					bus_transfer(steps[i], rdata, stalls);
					if (steps[i].check)
						compare(steps[i].name, expected_read(steps[i].addr), rdata);
				end
				default:
				begin
					// Wait states seen on DR writes since the last mark
					if (steps[i].check)
						compare(steps[i].name, 32'd1, {31'd0, data_stalls != 0});
					data_stalls = 0;
				end
			endcase
		end
		if (dut0.host0.props0.failures != 0)
		begin
			$display("Bus property assertions failed %0d times", dut0.host0.props0.failures);
			$display("** FAIL **");
			$fatal(1, "Assertion failures");
		end
		else
		begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== crc_ahb_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_properties
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input  wire logic             HCLK,
	input  wire logic             HRESETn,
	input  wire logic             HSELx,
	input  wire logic [1:0]       HTRANS,
	input  wire logic             HREADY,
	input  wire logic             HREADYOUT,
	input  wire logic             credit_return,
	input  wire crc_pkg::credit_t credits
);
	import crc_pkg::*;

	int unsigned failures;

	initial
		failures = 0;

	// A transfer offered on the bus finds the slave ready
	sampled_when_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(HSELx && (HTRANS == htrans_nonseq) && HREADY) |-> HREADYOUT)
	else
	begin
		failures++;
		$error("Transfer offered while HREADYOUT was low");
	end

	// One credit per buffer slot at most
	credits_bounded: assert property (@(posedge HCLK) disable iff (!HRESETn)
		credits <= credit_t'(BUFFER_DEPTH))
	else
	begin
		failures++;
		$error("Credit count above buffer depth");
	end

	// Credits only come back for words that were pushed
	credit_owed: assert property (@(posedge HCLK) disable iff (!HRESETn)
		credit_return |-> (credits != credit_t'(BUFFER_DEPTH)))
	else
	begin
		failures++;
		$error("Credit returned with none outstanding");
	end

endmodule

bind crc_host_interface crc_ahb_properties #(.BUFFER_DEPTH(BUFFER_DEPTH)) props0 (
	.HCLK(HCLK), .HRESETn(HRESETn), .HSELx(HSELx), .HTRANS(HTRANS),
	.HREADY(HREADY), .HREADYOUT(HREADYOUT), .credit_return(credit_return),
	.credits(credits)
);

`default_nettype wire

// ==== crc_ahb.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_ahb
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        HSELx,
	input  wire logic [31:0] HADDR,
	input  wire logic [1:0]  HTRANS,
	input  wire logic        HWRITE,
	input  wire logic [2:0]  HSIZE,
	input  wire logic [31:0] HWDATA,
	input  wire logic        HREADY,
	output logic [31:0]      HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP
);
	import crc_pkg::*;

	// Interface to buffer
	logic        push;
	logic [31:0] push_data;
	logic [1:0]  push_size;
	logic        credit_return;

	// Buffer to engine
	logic        word_valid;
	logic [31:0] word_data;
	logic [1:0]  word_size;
	logic        word_take;

	// Interface to engine
	logic        init_write;
	logic        poly_write;
	logic        chain_reset;
	logic [31:0] bus_wr;
	poly_size_t  poly_size;
	rev_in_t     rev_in;
	logic        rev_out;
	logic [31:0] crc_value;
	logic [31:0] init_value;
	logic [31:0] poly_value;
	logic        chain_busy;
	logic        reset_pending;

	//////////////////////////////////////////////////
	// Bus slave, buffer and engine
	//////////////////////////////////////////////////

	crc_host_interface #(.BUFFER_DEPTH(BUFFER_DEPTH)) host0 (
		.HCLK(HCLK), .HRESETn(HRESETn), .HSELx(HSELx), .HADDR(HADDR),
		.HTRANS(HTRANS), .HWRITE(HWRITE), .HSIZE(HSIZE), .HWDATA(HWDATA),
		.HREADY(HREADY), .credit_return(credit_return), .crc_value(crc_value),
		.init_value(init_value), .poly_value(poly_value), .chain_busy(chain_busy),
		.reset_pending(reset_pending), .HRDATA(HRDATA), .HREADYOUT(HREADYOUT),
		.HRESP(HRESP), .push(push), .push_data(push_data), .push_size(push_size),
		.init_write(init_write), .poly_write(poly_write), .chain_reset(chain_reset),
		.bus_wr(bus_wr), .poly_size(poly_size), .rev_in(rev_in), .rev_out(rev_out)
	);

	crc_input_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) buffer0 (
		.HCLK(HCLK), .HRESETn(HRESETn), .push(push), .push_data(push_data),
		.push_size(push_size), .word_take(word_take), .word_valid(word_valid),
		.word_data(word_data), .word_size(word_size), .credit_return(credit_return)
	);

	crc_engine engine0 (
		.HCLK(HCLK), .HRESETn(HRESETn), .word_valid(word_valid),
		.word_data(word_data), .word_size(word_size), .init_write(init_write),
		.poly_write(poly_write), .chain_reset(chain_reset), .bus_wr(bus_wr),
		.poly_size(poly_size), .rev_in(rev_in), .rev_out(rev_out),
		.word_take(word_take), .crc_value(crc_value), .init_value(init_value),
		.poly_value(poly_value), .chain_busy(chain_busy),
		.reset_pending(reset_pending)
	);

endmodule

`default_nettype wire

// ==== crc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_engine
(
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	input  wire logic                word_valid,
	input  wire logic [31:0]         word_data,
	input  wire logic [1:0]          word_size,
	input  wire logic                init_write,
	input  wire logic                poly_write,
	input  wire logic                chain_reset,
	input  wire logic [31:0]         bus_wr,
	input  wire crc_pkg::poly_size_t poly_size,
	input  wire crc_pkg::rev_in_t    rev_in,
	input  wire logic                rev_out,
	output logic                     word_take,
	output logic [31:0]              crc_value,
	output logic [31:0]              init_value,
	output logic [31:0]              poly_value,
	output logic                     chain_busy,
	output logic                     reset_pending
);
	import crc_pkg::*;

	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [31:0] crc_q;
	// Bytes still to fold, next one in the top byte
	logic [31:0] shift_q;
	logic [2:0]  bytes_left;
	logic        reset_req;
	logic        busy;
	logic [31:0] width_mask;
	logic [4:0]  width_shift;
	rev_in_t     eff_rev;
	logic [31:0] reversed;
	logic [31:0] taken_word;
	logic [2:0]  taken_bytes;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Bit reversal inside bytes, halfwords or the whole word
	function automatic logic [31:0] reverse_bits(input logic [31:0] d, input rev_in_t mode);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
		begin
			case (mode)
				rev_byte: r[i] = d[(i & ~7) + 7 - (i & 7)];
				rev_half: r[i] = d[(i & ~15) + 15 - (i & 15)];
				rev_word: r[i] = d[31 - i];
				default:  r[i] = d[i];
			endcase
		end
		return r;
	endfunction

	// One byte into the CRC, MSB first, right-aligned in the mask
	function automatic logic [31:0] crc_byte(
		input logic [31:0] crc,
		input logic [7:0]  data,
		input logic [31:0] poly,
		input logic [31:0] mask
	);
		logic [31:0] c;
		logic [31:0] top;
		logic        fb;
		c   = crc & mask;
		top = mask & ~(mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = ((c & top) != '0) ^ data[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	// Active width from CR
	always_comb
	begin
		case (poly_size)
			poly_16: width_shift = 5'd16;
			poly_8:  width_shift = 5'd24;
			poly_7:  width_shift = 5'd25;
			default: width_shift = 5'd0;
		endcase
	end

	// Mask of the active width, right-aligned
	assign width_mask = 32'hffff_ffff >> width_shift;

	//////////////////////////////////////////////////
	// Word intake
	//////////////////////////////////////////////////

	// Reversal never spans wider than the transfer itself
	always_comb
	begin
		eff_rev = rev_in;
		if ((word_size == size_byte) && (rev_in != rev_none))
			eff_rev = rev_byte;
		else if ((word_size == size_half) && (rev_in == rev_word))
			eff_rev = rev_half;
	end

	assign reversed = reverse_bits(word_data, eff_rev);

	// Valid bytes moved to the top so the MS byte goes first
	always_comb
	begin
		case (word_size)
			size_byte:
			begin
				taken_word  = {reversed[7:0], 24'h0};
				taken_bytes = 3'd1;
			end
			size_half:
			begin
				taken_word  = {reversed[15:0], 16'h0};
				taken_bytes = 3'd2;
			end
			// Word, the spare code treated alike
			default:
			begin
				taken_word  = reversed;
				taken_bytes = 3'd4;
			end
		endcase
	end

	assign busy      = (bytes_left != 3'd0);
	assign word_take = word_valid && !busy;

	//////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			bytes_left <= 3'd0;
			reset_req  <= 1'b0;
		end
		else
		begin
			if (word_take)
				bytes_left <= taken_bytes;
			else if (busy)
				bytes_left <= bytes_left - 1'b1;
			// Reload waits for the queue to drain
			if (chain_reset)
				reset_req <= 1'b1;
			else if (reset_req && !busy && !word_valid)
				reset_req <= 1'b0;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (word_take)
			shift_q <= taken_word;
		else if (busy)
			shift_q <= shift_q << 8;
	end

	// INIT, POL and the running CRC
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= init_reset_value;
			poly_q <= poly_reset_value;
			crc_q  <= init_reset_value;
		end
		else
		begin
			if (init_write)
				init_q <= bus_wr;
			if (poly_write)
				poly_q <= bus_wr;
			if (busy)
				crc_q <= crc_byte(crc_q, shift_q[31:24], poly_q, width_mask);
			else if (reset_req && !word_valid)
				crc_q <= init_q & width_mask;
		end
	end

	// Output reversal over the active width only
	assign crc_value = rev_out ? (reverse_bits(crc_q & width_mask, rev_word) >> width_shift)
	                           : (crc_q & width_mask);

	assign init_value    = init_q;
	assign poly_value    = poly_q;
	// A pending reload counts as busy for DR reads
	assign chain_busy    = busy || reset_req;
	assign reset_pending = reset_req;

endmodule

`default_nettype wire

// ==== crc_input_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_input_buffer
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        push,
	input  wire logic [31:0] push_data,
	input  wire logic [1:0]  push_size,
	input  wire logic        word_take,
	output logic             word_valid,
	output logic [31:0]      word_data,
	output logic [1:0]       word_size,
	output logic             credit_return
);
	import crc_pkg::*;

	// A depth of one still needs a one bit pointer
	localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;

	logic [31:0]      data_mem [BUFFER_DEPTH];
	logic [1:0]       size_mem [BUFFER_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t          fill;
	logic             pop;

	// Wrap at the depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUFFER_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign pop = word_take && word_valid;

	// Slot storage
	always_ff @(posedge HCLK)
	begin
		if (push)
		begin
			data_mem[wr_ptr] <= push_data;
			size_mem[wr_ptr] <= push_size;
		end
	end

	// Pointers and fill level
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				fill <= fill + 1'b1;
			else if (pop && !push)
				fill <= fill - 1'b1;
		end
	end

	// Head of queue, empty when word_valid is low
	assign word_valid    = (fill != '0);
	assign word_data     = data_mem[rd_ptr];
	assign word_size     = size_mem[rd_ptr];
	assign credit_return = pop;

endmodule

`default_nettype wire

// ==== crc_host_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_host_interface
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	input  wire logic                HSELx,
	input  wire logic [31:0]         HADDR,
	input  wire logic [1:0]          HTRANS,
	input  wire logic                HWRITE,
	input  wire logic [2:0]          HSIZE,
	input  wire logic [31:0]         HWDATA,
	input  wire logic                HREADY,
	input  wire logic                credit_return,
	input  wire logic [31:0]         crc_value,
	input  wire logic [31:0]         init_value,
	input  wire logic [31:0]         poly_value,
	input  wire logic                chain_busy,
	input  wire logic                reset_pending,
	output logic [31:0]              HRDATA,
	output logic                     HREADYOUT,
	output logic                     HRESP,
	output logic                     push,
	output logic [31:0]              push_data,
	output logic [1:0]               push_size,
	output logic                     init_write,
	output logic                     poly_write,
	output logic                     chain_reset,
	output logic [31:0]              bus_wr,
	output crc_pkg::poly_size_t      poly_size,
	output crc_pkg::rev_in_t         rev_in,
	output logic                     rev_out
);
	import crc_pkg::*;

	// Address phase held over into the data phase
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	logic       sample_bus;
	logic       write_en;
	logic       read_en;
	logic       dr_write;
	logic       dr_read;
	logic       init_req;
	logic       cr_write;
	logic       idr_write;
	logic       read_wait;
	logic [7:0] idr_q;
	credit_t    credits;

	//////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////

	// Host back-pressure or our own wait state freezes the pipeline
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= htrans_idle;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSELx;
			htrans_pp <= HTRANS;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	// Data phase decode
	assign write_en  = hselx_pp && (htrans_pp == htrans_nonseq) && hwrite_pp;
	assign read_en   = hselx_pp && (htrans_pp == htrans_nonseq) && !hwrite_pp;
	assign dr_write  = write_en && (haddr_pp == crc_dr_addr);
	assign dr_read   = read_en && (haddr_pp == crc_dr_addr);
	assign init_req  = write_en && (haddr_pp == crc_init_addr);
	assign cr_write  = write_en && (haddr_pp == crc_cr_addr);
	assign idr_write = write_en && (haddr_pp == crc_idr_addr);

	// Data words go to the buffer only against a credit
	assign push       = dr_write && (credits != '0);
	assign push_data  = HWDATA;
	assign push_size  = hsize_pp;
	assign bus_wr     = HWDATA;
	assign poly_write = write_en && (haddr_pp == crc_pol_addr);
	// INIT must not change under a reload still waiting in the engine
	assign init_write = init_req && !reset_pending;
	assign chain_reset = cr_write && HWDATA[cr_reset_bit];

	//////////////////////////////////////////////////
	// Credits
	//////////////////////////////////////////////////

	// One credit per free buffer slot
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			credits <= credit_t'(BUFFER_DEPTH);
		else if (push && !credit_return)
			credits <= credits - 1'b1;
		else if (credit_return && !push)
			credits <= credits + 1'b1;
	end

	// Any credit out means a word still sits in the buffer
	assign read_wait = chain_busy || (credits != credit_t'(BUFFER_DEPTH));

	// Wait states
	assign HREADYOUT = !((dr_write && (credits == '0)) ||
	                     (dr_read && read_wait) ||
	                     (init_req && reset_pending));

	// Never an error response
	assign HRESP = 1'b0;

	//////////////////////////////////////////////////
	// Control and scratch registers
	//////////////////////////////////////////////////

	// CR[0] is a pulse only, nothing stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_size <= poly_32;
			rev_in    <= rev_none;
			rev_out   <= 1'b0;
		end
		else if (cr_write)
		begin
			poly_size <= poly_size_t'(HWDATA[cr_poly_lsb +: 2]);
			rev_in    <= rev_in_t'(HWDATA[cr_rev_in_lsb +: 2]);
			rev_out   <= HWDATA[cr_rev_out_bit];
		end
	end

	// Scratch byte, host use only
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			idr_q <= 8'h00;
		else if (idr_write)
			idr_q <= HWDATA[7:0];
	end

	// Read mux on the registered offset
	always_comb
	begin
		case (haddr_pp)
			crc_dr_addr:   HRDATA = crc_value;
			crc_idr_addr:  HRDATA = {24'h0, idr_q};
			crc_cr_addr:   HRDATA = {24'h0, rev_out, rev_in, poly_size, 3'b000};
			crc_init_addr: HRDATA = init_value;
			crc_pol_addr:  HRDATA = poly_value;
			default:       HRDATA = 32'h0;
		endcase
	end

endmodule

`default_nettype wire

// ==== crc_pkg.sv ====
`default_nettype none

package crc_pkg;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	// Word offsets decoded from HADDR[4:2]
	localparam logic [2:0] crc_dr_addr   = 3'd0;
	localparam logic [2:0] crc_idr_addr  = 3'd1;
	localparam logic [2:0] crc_cr_addr   = 3'd2;
	localparam logic [2:0] crc_init_addr = 3'd4;
	localparam logic [2:0] crc_pol_addr  = 3'd5;

	// Only NONSEQ starts a transfer, SEQ and BUSY are ignored
	localparam logic [1:0] htrans_idle   = 2'b00;
	localparam logic [1:0] htrans_nonseq = 2'b10;

	// Low two bits of HSIZE
	localparam logic [1:0] size_byte = 2'b00;
	localparam logic [1:0] size_half = 2'b01;
	localparam logic [1:0] size_word = 2'b10;

	//////////////////////////////////////////////////
	// Control register fields
	//////////////////////////////////////////////////

	// CR[4:3]
	typedef enum logic [1:0] {poly_32, poly_16, poly_8, poly_7} poly_size_t;

	// CR[6:5]
	typedef enum logic [1:0] {rev_none, rev_byte, rev_half, rev_word} rev_in_t;

	localparam int cr_reset_bit   = 0;
	localparam int cr_poly_lsb    = 3;
	localparam int cr_rev_in_lsb  = 5;
	localparam int cr_rev_out_bit = 7;

	// Values after reset
	localparam logic [31:0] init_reset_value = 32'hffff_ffff;
	localparam logic [31:0] poly_reset_value = 32'h04c1_1db7;

	// Deepest input buffer supported, sizes the credit count
	localparam int max_buffer_depth = 15;
	typedef logic [$clog2(max_buffer_depth + 1) - 1:0] credit_t;

endpackage

`default_nettype wire
